/* design/id_defs.svh */
/* instruction decode field positions and widths
   shared by the decode package and the ID stage RTL */
`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

`define ID_INSN_W       32

// major opcode
`define ID_OPC_MSB      31
`define ID_OPC_LSB      26

// register operand fields
`define ID_RD_MSB       25
`define ID_RD_LSB       21
`define ID_RA_MSB       20
`define ID_RA_LSB       16
`define ID_RB_MSB       15
`define ID_RB_LSB       11
`define ID_REG_ADDR_W   5

// jump-and-link target register
`define ID_LINK_REG     5'd9

// sync group subcode, bits 25..23
`define ID_XSYNC_MSB    25
`define ID_XSYNC_LSB    23
`define ID_XSYNC_SYS    3'b000
`define ID_XSYNC_TRAP   3'b010

// second alu field and compare code
`define ID_ALUOP2_W     4
`define ID_ALUOP2_LSB   6
`define ID_COMP_W       4
`define ID_COMP_LSB     21

`endif

/* design/id_pkg.sv */
/* decode types: opcodes, alu and load/store operations, operand selects
   and the execute-stage control bundle */
`include "id_defs.svh"

package id_pkg;

	// or1k major opcodes kept by this core
	typedef enum logic [5:0] {
		OPC_J       = 6'h00,
		OPC_JAL     = 6'h01,
		OPC_BNF     = 6'h03,
		OPC_BF      = 6'h04,
		OPC_NOP     = 6'h05,
		OPC_MOVHI   = 6'h06,
		OPC_XSYNC   = 6'h08,
		OPC_RFE     = 6'h09,
		OPC_JR      = 6'h11,
		OPC_JALR    = 6'h12,
		OPC_LWZ     = 6'h21,
		OPC_LWS     = 6'h22,
		OPC_LBZ     = 6'h23,
		OPC_LBS     = 6'h24,
		OPC_LHZ     = 6'h25,
		OPC_LHS     = 6'h26,
		OPC_ADDI    = 6'h27,
		OPC_ADDIC   = 6'h28,
		OPC_ANDI    = 6'h29,
		OPC_ORI     = 6'h2A,
		OPC_XORI    = 6'h2B,
		OPC_MFSPR   = 6'h2D,
		OPC_SH_ROTI = 6'h2E,
		OPC_SFXXI   = 6'h2F,
		OPC_MTSPR   = 6'h30,
		OPC_SW      = 6'h35,
		OPC_SB      = 6'h36,
		OPC_SH      = 6'h37,
		OPC_ALU     = 6'h38,
		OPC_SFXX    = 6'h39
	} opcode_e;

	typedef enum logic [4:0] {
		ALU_ADD   = 5'h00,
		ALU_ADDC  = 5'h01,
		ALU_SUB   = 5'h02,
		ALU_AND   = 5'h03,
		ALU_OR    = 5'h04,
		ALU_XOR   = 5'h05,
		ALU_MUL   = 5'h06,
		ALU_SHROT = 5'h08,
		ALU_DIV   = 5'h09,
		ALU_DIVU  = 5'h0A,
		ALU_MULU  = 5'h0B,
		ALU_MOVHI = 5'h0C,
		ALU_COMP  = 5'h0E,
		ALU_NOP   = 5'h0F
	} alu_op_e;

	// bit 3 marks a store, bit 0 a sign-extending load
	typedef enum logic [3:0] {
		LSU_NOP = 4'b0000,
		LSU_LBZ = 4'b0010,
		LSU_LBS = 4'b0011,
		LSU_LHZ = 4'b0100,
		LSU_LHS = 4'b0101,
		LSU_LWZ = 4'b0110,
		LSU_LWS = 4'b0111,
		LSU_SB  = 4'b1010,
		LSU_SH  = 4'b1100,
		LSU_SW  = 4'b1110
	} lsu_op_e;

	typedef enum logic [2:0] {
		RFWB_NONE = 3'd0,
		RFWB_ALU  = 3'd1,
		RFWB_LSU  = 3'd2,
		RFWB_SPRS = 3'd3,
		RFWB_LR   = 3'd4
	} rfwb_src_e;

	typedef enum logic [1:0] {
		SEL_RF      = 2'd0,
		SEL_IMM     = 2'd1,
		SEL_EX_FORW = 2'd2,
		SEL_WB_FORW = 2'd3
	} sel_e;

	typedef struct packed {
		alu_op_e                   alu_op;
		logic [`ID_ALUOP2_W-1:0]   alu_op2;
		logic [`ID_COMP_W-1:0]     comp_op;
		logic                      spr_read;
		logic                      spr_write;
		rfwb_src_e                 rfwb_src;
		logic                      rfwb_en;
		logic [`ID_REG_ADDR_W-1:0] rf_addrw;
		logic                      except_illegal;
		logic                      sig_syscall;
		logic                      sig_trap;
		logic [`ID_INSN_W-1:0]     simm;
	} ex_ctrl_t;

endpackage

/* design/insn_decoder.sv */
/* instruction decoder
   turns the ID instruction word into execute controls, lsu opcode and immediate */
`timescale 1ns/1ps
`include "id_defs.svh"

module insn_decoder (
	input  logic [`ID_INSN_W-1:0] insn,
	input  logic                  du_hwbkpt,
	output id_pkg::ex_ctrl_t      id_ctrl,
	output id_pkg::lsu_op_e       id_lsu_op,
	output logic                  id_void
);

	id_pkg::opcode_e opc;
	logic [4:0]      alu_sub;
	logic [2:0]      xsync_sub;

	assign opc       = id_pkg::opcode_e'(insn[`ID_OPC_MSB:`ID_OPC_LSB]);
	assign alu_sub   = insn[4:0];
	assign xsync_sub = insn[`ID_XSYNC_MSB:`ID_XSYNC_LSB];

	// l.nop with bit 16 set is a void slot
	assign id_void = (opc == id_pkg::OPC_NOP) & insn[16];

	always_comb begin
		id_ctrl = '0;
		id_ctrl.alu_op = id_pkg::ALU_NOP;
		id_ctrl.rfwb_src = id_pkg::RFWB_NONE;
		id_ctrl.alu_op2 = insn[`ID_ALUOP2_LSB +: `ID_ALUOP2_W];
		id_ctrl.comp_op = insn[`ID_COMP_LSB +: `ID_COMP_W];
		id_ctrl.rf_addrw = insn[`ID_RD_MSB:`ID_RD_LSB];
		id_ctrl.except_illegal = 1'b0;
		id_lsu_op = id_pkg::LSU_NOP;

		case (opc)
			id_pkg::OPC_J, id_pkg::OPC_BNF, id_pkg::OPC_BF, id_pkg::OPC_NOP,
			id_pkg::OPC_XSYNC, id_pkg::OPC_RFE, id_pkg::OPC_JR: begin
				// control flow only, nothing to execute here
			end
			id_pkg::OPC_JAL, id_pkg::OPC_JALR: begin
				id_ctrl.rfwb_src = id_pkg::RFWB_LR;
				id_ctrl.rfwb_en = 1'b1;
				id_ctrl.rf_addrw = `ID_LINK_REG;
			end
			id_pkg::OPC_MOVHI: begin
				id_ctrl.alu_op = id_pkg::ALU_MOVHI;
				id_ctrl.rfwb_src = id_pkg::RFWB_ALU;
				id_ctrl.rfwb_en = 1'b1;
			end
			id_pkg::OPC_ADDI, id_pkg::OPC_ADDIC, id_pkg::OPC_ANDI,
			id_pkg::OPC_ORI, id_pkg::OPC_XORI, id_pkg::OPC_SH_ROTI: begin
				case (opc)
					id_pkg::OPC_ADDI:  id_ctrl.alu_op = id_pkg::ALU_ADD;
					id_pkg::OPC_ADDIC: id_ctrl.alu_op = id_pkg::ALU_ADDC;
					id_pkg::OPC_ANDI:  id_ctrl.alu_op = id_pkg::ALU_AND;
					id_pkg::OPC_ORI:   id_ctrl.alu_op = id_pkg::ALU_OR;
					id_pkg::OPC_XORI:  id_ctrl.alu_op = id_pkg::ALU_XOR;
					default:           id_ctrl.alu_op = id_pkg::ALU_SHROT;
				endcase
				id_ctrl.rfwb_src = id_pkg::RFWB_ALU;
				id_ctrl.rfwb_en = 1'b1;
			end
			id_pkg::OPC_ALU: begin
				id_ctrl.alu_op = id_pkg::alu_op_e'({1'b0, insn[3:0]});
				id_ctrl.rfwb_src = id_pkg::RFWB_ALU;
				id_ctrl.rfwb_en = 1'b1;
				// no multiplier or divider in this core
				id_ctrl.except_illegal = (alu_sub == id_pkg::ALU_MUL) |
					(alu_sub == id_pkg::ALU_MULU) |
					(alu_sub == id_pkg::ALU_DIV) |
					(alu_sub == id_pkg::ALU_DIVU);
			end
			id_pkg::OPC_SFXX, id_pkg::OPC_SFXXI: begin
				id_ctrl.alu_op = id_pkg::ALU_COMP;
			end
			id_pkg::OPC_MFSPR: begin
				id_ctrl.spr_read = 1'b1;
				id_ctrl.rfwb_src = id_pkg::RFWB_SPRS;
				id_ctrl.rfwb_en = 1'b1;
			end
			id_pkg::OPC_MTSPR: begin
				id_ctrl.spr_write = 1'b1;
			end
			id_pkg::OPC_LWZ, id_pkg::OPC_LWS, id_pkg::OPC_LBZ,
			id_pkg::OPC_LBS, id_pkg::OPC_LHZ, id_pkg::OPC_LHS: begin
				case (opc)
					id_pkg::OPC_LWZ: id_lsu_op = id_pkg::LSU_LWZ;
					id_pkg::OPC_LWS: id_lsu_op = id_pkg::LSU_LWS;
					id_pkg::OPC_LBZ: id_lsu_op = id_pkg::LSU_LBZ;
					id_pkg::OPC_LBS: id_lsu_op = id_pkg::LSU_LBS;
					id_pkg::OPC_LHZ: id_lsu_op = id_pkg::LSU_LHZ;
					default:         id_lsu_op = id_pkg::LSU_LHS;
				endcase
				id_ctrl.rfwb_src = id_pkg::RFWB_LSU;
				id_ctrl.rfwb_en = 1'b1;
			end
			id_pkg::OPC_SW: id_lsu_op = id_pkg::LSU_SW;
			id_pkg::OPC_SB: id_lsu_op = id_pkg::LSU_SB;
			id_pkg::OPC_SH: id_lsu_op = id_pkg::LSU_SH;
			default: begin
				id_ctrl.except_illegal = 1'b1;
			end
		endcase

		id_ctrl.sig_syscall = (opc == id_pkg::OPC_XSYNC) & (xsync_sub == `ID_XSYNC_SYS);
		// hardware breakpoint from debug unit rides on the trap
		id_ctrl.sig_trap = ((opc == id_pkg::OPC_XSYNC) & (xsync_sub == `ID_XSYNC_TRAP)) |
			du_hwbkpt;

		// immediate extension
		case (opc)
			id_pkg::OPC_LWZ, id_pkg::OPC_LWS, id_pkg::OPC_LBZ, id_pkg::OPC_LBS,
			id_pkg::OPC_LHZ, id_pkg::OPC_LHS, id_pkg::OPC_ADDI, id_pkg::OPC_ADDIC,
			id_pkg::OPC_XORI, id_pkg::OPC_SFXXI:
				id_ctrl.simm = {{16{insn[15]}}, insn[15:0]};
			// spr number split across rd and the low bits
			id_pkg::OPC_MTSPR:
				id_ctrl.simm = {16'b0, insn[`ID_RD_MSB:`ID_RD_LSB], insn[10:0]};
			// store offset, sign taken from bit 25
			id_pkg::OPC_SW, id_pkg::OPC_SB, id_pkg::OPC_SH:
				id_ctrl.simm = {{16{insn[25]}}, insn[`ID_RD_MSB:`ID_RD_LSB], insn[10:0]};
			default:
				id_ctrl.simm = {16'b0, insn[15:0]};
		endcase
	end

endmodule

/* design/operand_forward.sv */
/* operand select for the two alu inputs
   forwards from EX or WB when the source register is being written */
`timescale 1ns/1ps
`include "id_defs.svh"

module operand_forward (
	input  logic [`ID_REG_ADDR_W-1:0] ra,
	input  logic [`ID_REG_ADDR_W-1:0] rb,
	input  logic                      sel_imm,
	input  id_pkg::ex_ctrl_t          ex_ctrl,
	input  logic [`ID_REG_ADDR_W-1:0] wb_rfaddrw,
	input  logic                      wbforw_valid,
	output id_pkg::sel_e              sel_a,
	output id_pkg::sel_e              sel_b
);

	// EX result is younger than WB so it wins
	function automatic id_pkg::sel_e fwd_sel(input logic [`ID_REG_ADDR_W-1:0] src);
		id_pkg::sel_e sel;
		if ((src == ex_ctrl.rf_addrw) && ex_ctrl.rfwb_en)
			sel = id_pkg::SEL_EX_FORW;
		else if ((src == wb_rfaddrw) && wbforw_valid)
			sel = id_pkg::SEL_WB_FORW;
		else
			sel = id_pkg::SEL_RF;
		return sel;
	endfunction

	always_comb begin
		sel_a = fwd_sel(ra);
		// immediate operand overrides any forward on b
		if (sel_imm)
			sel_b = id_pkg::SEL_IMM;
		else
			sel_b = fwd_sel(rb);
	end

endmodule

/* design/id_ex_stage.sv */
/* ID/EX control register
   holds on ex_freeze, inserts a bubble on id_freeze and clears on flush */
`timescale 1ns/1ps

module id_ex_stage (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             ex_freeze,
	input  logic             id_freeze,
	input  logic             ex_flushpipe,
	input  id_pkg::ex_ctrl_t id_ctrl,
	output id_pkg::ex_ctrl_t ex_ctrl
);

	id_pkg::ex_ctrl_t ctrl_next;
	logic             bubble;

	// inactive control word, alu idle and no write-back
	function automatic id_pkg::ex_ctrl_t idle_ctrl();
		id_pkg::ex_ctrl_t c;
		c = '0;
		c.alu_op = id_pkg::ALU_NOP;
		c.rfwb_src = id_pkg::RFWB_NONE;
		return c;
	endfunction

	assign bubble = id_freeze & ~ex_freeze;

	always_comb begin
		ctrl_next = ex_ctrl;
		if (ex_flushpipe || bubble) begin
			ctrl_next = idle_ctrl();
			// immediate still follows ID unless EX is frozen
			ctrl_next.simm = ex_freeze ? ex_ctrl.simm : id_ctrl.simm;
		end else if (!ex_freeze) begin
			ctrl_next = id_ctrl;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			ex_ctrl <= idle_ctrl();
		else
			ex_ctrl <= ctrl_next;
	end

endmodule

/* design/id_decode_top.sv */
/* decode control of the ID stage
   decoder, ID/EX register and operand forwarding selects */
`timescale 1ns/1ps
`include "id_defs.svh"

module id_decode_top (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic [`ID_INSN_W-1:0]     id_insn,
	input  logic                      du_hwbkpt,
	input  logic                      sel_imm,
	input  logic                      ex_freeze,
	input  logic                      id_freeze,
	input  logic                      ex_flushpipe,
	input  logic [`ID_REG_ADDR_W-1:0] wb_rfaddrw,
	input  logic                      wbforw_valid,
	output id_pkg::lsu_op_e           id_lsu_op,
	output logic                      id_void,
	output id_pkg::sel_e              sel_a,
	output id_pkg::sel_e              sel_b,
	output id_pkg::ex_ctrl_t          ex_ctrl
);

	id_pkg::ex_ctrl_t id_ctrl;

	insn_decoder u_decoder (
		.insn      (id_insn),
		.du_hwbkpt (du_hwbkpt),
		.id_ctrl   (id_ctrl),
		.id_lsu_op (id_lsu_op),
		.id_void   (id_void)
	);

	id_ex_stage u_id_ex (
		.clk          (clk),
		.arst_n       (arst_n),
		.ex_freeze    (ex_freeze),
		.id_freeze    (id_freeze),
		.ex_flushpipe (ex_flushpipe),
		.id_ctrl      (id_ctrl),
		.ex_ctrl      (ex_ctrl)
	);

	// sources come from the instruction still in ID
	operand_forward u_forward (
		.ra           (id_insn[`ID_RA_MSB:`ID_RA_LSB]),
		.rb           (id_insn[`ID_RB_MSB:`ID_RB_LSB]),
		.sel_imm      (sel_imm),
		.ex_ctrl      (ex_ctrl),
		.wb_rfaddrw   (wb_rfaddrw),
		.wbforw_valid (wbforw_valid),
		.sel_a        (sel_a),
		.sel_b        (sel_b)
	);

endmodule

/* tests/id_decode_tb.sv */
/* testbench for the ID decode control
   random and directed instructions checked against a reference decode */
`timescale 1ns/1ps
`include "id_defs.svh"

module id_decode_tb;

	localparam int n_random        = 400;
	localparam int n_mixed         = 200;
	localparam int n_directed      = 16;
	localparam int watchdog_cycles = 16 + n_random + n_mixed + n_directed + 40;

	// retained opcodes first, then a few unused codes
	localparam logic [5:0] opc_pool [35] = '{
		6'h00, 6'h01, 6'h03, 6'h04, 6'h05, 6'h06, 6'h08, 6'h09, 6'h11, 6'h12,
		6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h28, 6'h29, 6'h2A,
		6'h2B, 6'h2D, 6'h2E, 6'h2F, 6'h30, 6'h35, 6'h36, 6'h37, 6'h38, 6'h39,
		6'h02, 6'h07, 6'h13, 6'h1C, 6'h3F
	};

	logic                  clk;
	logic                  arst_n;
	logic [`ID_INSN_W-1:0] id_insn;
	logic                  du_hwbkpt;
	logic                  sel_imm;
	logic                  ex_freeze;
	logic                  id_freeze;
	logic                  ex_flushpipe;
	logic [4:0]            wb_rfaddrw;
	logic                  wbforw_valid;
	id_pkg::lsu_op_e       id_lsu_op;
	logic                  id_void;
	id_pkg::sel_e          sel_a;
	id_pkg::sel_e          sel_b;
	id_pkg::ex_ctrl_t      ex_ctrl;

	id_pkg::ex_ctrl_t      exp_ctrl;
	id_pkg::ex_ctrl_t      idle_word;
	id_pkg::lsu_op_e       exp_lsu;
	logic                  exp_void;
	id_pkg::sel_e          exp_sel_a;
	id_pkg::sel_e          exp_sel_b;
	logic                  pre_accept;
	integer                seed;

	id_decode_top dut0 (
		.clk          (clk),
		.arst_n       (arst_n),
		.id_insn      (id_insn),
		.du_hwbkpt    (du_hwbkpt),
		.sel_imm      (sel_imm),
		.ex_freeze    (ex_freeze),
		.id_freeze    (id_freeze),
		.ex_flushpipe (ex_flushpipe),
		.wb_rfaddrw   (wb_rfaddrw),
		.wbforw_valid (wbforw_valid),
		.id_lsu_op    (id_lsu_op),
		.id_void      (id_void),
		.sel_a        (sel_a),
		.sel_b        (sel_b),
		.ex_ctrl      (ex_ctrl)
	);

	always #50 clk = ~clk;

	function automatic id_pkg::ex_ctrl_t inactive_ctrl();
		id_pkg::ex_ctrl_t c;
		c = '0;
		c.alu_op = id_pkg::ALU_NOP;
		c.rfwb_src = id_pkg::RFWB_NONE;
		return c;
	endfunction

	function automatic logic is_retained(input logic [5:0] op);
		logic hit;
		int   i;
		hit = 1'b0;
		for (i = 0; i < 30; i++)
			if (opc_pool[i] == op)
				hit = 1'b1;
		return hit;
	endfunction

	function automatic id_pkg::ex_ctrl_t decode_word(input logic [31:0] w, input logic bk);
		id_pkg::ex_ctrl_t c;
		logic [5:0]       op;
		c = inactive_ctrl();
		op = w[31:26];
		c.alu_op2 = w[9:6];
		c.comp_op = w[24:21];
		c.rf_addrw = w[25:21];
		case (op)
			6'h06: c.alu_op = id_pkg::ALU_MOVHI;
			6'h27: c.alu_op = id_pkg::ALU_ADD;
			6'h28: c.alu_op = id_pkg::ALU_ADDC;
			6'h29: c.alu_op = id_pkg::ALU_AND;
			6'h2A: c.alu_op = id_pkg::ALU_OR;
			6'h2B: c.alu_op = id_pkg::ALU_XOR;
			6'h2E: c.alu_op = id_pkg::ALU_SHROT;
			6'h2F, 6'h39: c.alu_op = id_pkg::ALU_COMP;
			6'h38: c.alu_op = id_pkg::alu_op_e'({1'b0, w[3:0]});
			default: c.alu_op = id_pkg::ALU_NOP;
		endcase
		case (op)
			6'h01, 6'h12: begin
				c.rfwb_src = id_pkg::RFWB_LR;
				c.rf_addrw = 5'd9;
			end
			6'h2D: c.rfwb_src = id_pkg::RFWB_SPRS;
			6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26: c.rfwb_src = id_pkg::RFWB_LSU;
			6'h06, 6'h27, 6'h28, 6'h29, 6'h2A, 6'h2B, 6'h2E, 6'h38:
				c.rfwb_src = id_pkg::RFWB_ALU;
			default: c.rfwb_src = id_pkg::RFWB_NONE;
		endcase
		c.rfwb_en = (c.rfwb_src != id_pkg::RFWB_NONE);
		c.spr_read = (op == 6'h2D);
		c.spr_write = (op == 6'h30);
		c.sig_syscall = (op == 6'h08) && (w[25:23] == 3'b000);
		c.sig_trap = ((op == 6'h08) && (w[25:23] == 3'b010)) || bk;
		// mul and div sub-ops have no unit behind them
		if (op == 6'h38)
			c.except_illegal = w[4:0] inside {5'h06, 5'h09, 5'h0A, 5'h0B};
		else
			c.except_illegal = !is_retained(op);
		case (op)
			6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h28, 6'h2B, 6'h2F:
				c.simm = {{16{w[15]}}, w[15:0]};
			6'h30: c.simm = {16'h0, w[25:21], w[10:0]};
			6'h35, 6'h36, 6'h37: c.simm = {{16{w[25]}}, w[25:21], w[10:0]};
			default: c.simm = {16'h0, w[15:0]};
		endcase
		return c;
	endfunction

	function automatic id_pkg::lsu_op_e lsu_of(input logic [5:0] op);
		case (op)
			6'h21: return id_pkg::LSU_LWZ;
			6'h22: return id_pkg::LSU_LWS;
			6'h23: return id_pkg::LSU_LBZ;
			6'h24: return id_pkg::LSU_LBS;
			6'h25: return id_pkg::LSU_LHZ;
			6'h26: return id_pkg::LSU_LHS;
			6'h35: return id_pkg::LSU_SW;
			6'h36: return id_pkg::LSU_SB;
			6'h37: return id_pkg::LSU_SH;
			default: return id_pkg::LSU_NOP;
		endcase
	endfunction

	function automatic id_pkg::sel_e forward_select(input logic [4:0] src, input logic force_imm,
		input id_pkg::ex_ctrl_t ex, input logic [4:0] wba, input logic wbv);
		if (force_imm)
			return id_pkg::SEL_IMM;
		if (ex.rfwb_en && (src == ex.rf_addrw))
			return id_pkg::SEL_EX_FORW;
		if (wbv && (src == wba))
			return id_pkg::SEL_WB_FORW;
		return id_pkg::SEL_RF;
	endfunction

	// flush beats hold, hold beats bubble
	function automatic id_pkg::ex_ctrl_t advance_model(input id_pkg::ex_ctrl_t cur,
		input id_pkg::ex_ctrl_t dec, input logic idf, input logic exf, input logic fl);
		id_pkg::ex_ctrl_t c;
		c = cur;
		if (fl) begin
			c = inactive_ctrl();
			c.simm = exf ? cur.simm : dec.simm;
		end else if (!exf) begin
			if (idf) begin
				c = inactive_ctrl();
				c.simm = dec.simm;
			end else begin
				c = dec;
			end
		end
		return c;
	endfunction

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			exp_ctrl <= inactive_ctrl();
		else
			exp_ctrl <= advance_model(exp_ctrl, decode_word(id_insn, du_hwbkpt),
				id_freeze, ex_freeze, ex_flushpipe);
	end

	assign idle_word = inactive_ctrl();

	always_comb begin
		exp_lsu = lsu_of(id_insn[31:26]);
		exp_void = (id_insn[31:26] == 6'h05) && id_insn[16];
		exp_sel_a = forward_select(id_insn[20:16], 1'b0, exp_ctrl, wb_rfaddrw, wbforw_valid);
		exp_sel_b = forward_select(id_insn[15:11], sel_imm, exp_ctrl, wb_rfaddrw, wbforw_valid);
	end

	task automatic report_mismatch(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		$display("ERR %s expected %h got %h", name, expected, actual);
		$display("tests failed");
		$fatal(1, "check on %s failed", name);
	endtask

	// outputs are sampled on the falling edge, half a cycle after the drive
	assert property (@(negedge clk) ex_ctrl == exp_ctrl)
		else report_mismatch("ex_ctrl", 64'(exp_ctrl), 64'(ex_ctrl));
	assert property (@(negedge clk) !pre_accept || (ex_ctrl == idle_word))
		else report_mismatch("ex_ctrl idle", 64'(idle_word), 64'(ex_ctrl));
	assert property (@(negedge clk) id_lsu_op == exp_lsu)
		else report_mismatch("id_lsu_op", 64'(exp_lsu), 64'(id_lsu_op));
	assert property (@(negedge clk) id_void == exp_void)
		else report_mismatch("id_void", 64'(exp_void), 64'(id_void));
	assert property (@(negedge clk) sel_a == exp_sel_a)
		else report_mismatch("sel_a", 64'(exp_sel_a), 64'(sel_a));
	assert property (@(negedge clk) sel_b == exp_sel_b)
		else report_mismatch("sel_b", 64'(exp_sel_b), 64'(sel_b));

	function automatic logic [31:0] pack_insn(input logic [5:0] op, input logic [4:0] rd,
		input logic [4:0] ra, input logic [4:0] rb, input logic [10:0] low);
		return {op, rd, ra, rb, low};
	endfunction

	task automatic make_insn(output logic [31:0] w);
		logic [31:0] r;
		logic [5:0]  op;
		int          idx;
		r = $random(seed);
		idx = {$random(seed)} % 35;
		op = opc_pool[idx];
		w = {op, r[25:0]};
		// push some picks onto the mul/div and sync subcodes
		if ((op == 6'h38) && r[31])
			w[4:0] = r[30] ? (r[29] ? 5'h06 : 5'h09) : (r[29] ? 5'h0A : 5'h0B);
		if ((op == 6'h08) && r[31])
			w[25:23] = {1'b0, r[30], 1'b0};
	endtask

	task automatic drive_random(input int n, input logic with_ctrl);
		logic [31:0] w;
		logic [31:0] r;
		repeat (n) begin
			make_insn(w);
			r = $random(seed);
			@(posedge clk);
			id_insn <= w;
			du_hwbkpt <= (r[2:0] == 3'd0);
			sel_imm <= r[3];
			wb_rfaddrw <= r[8:4];
			wbforw_valid <= r[9];
			id_freeze <= with_ctrl && (r[11:10] == 2'd0);
			ex_freeze <= with_ctrl && (r[13:12] == 2'd0);
			ex_flushpipe <= with_ctrl && (r[16:14] == 3'd0);
		end
	endtask

	task automatic apply_cycle(input logic [31:0] w, input logic idf, input logic exf,
		input logic fl, input logic imm, input logic [4:0] wba, input logic wbv);
		@(posedge clk);
		id_insn <= w;
		du_hwbkpt <= 1'b0;
		id_freeze <= idf;
		ex_freeze <= exf;
		ex_flushpipe <= fl;
		sel_imm <= imm;
		wb_rfaddrw <= wba;
		wbforw_valid <= wbv;
	endtask

	initial begin
		seed = 66;
		clk = 1'b0;
		arst_n <= 1'b0;
		id_insn <= 32'h1400_0000;
		du_hwbkpt <= 1'b0;
		sel_imm <= 1'b0;
		ex_freeze <= 1'b1;
		id_freeze <= 1'b0;
		ex_flushpipe <= 1'b0;
		wb_rfaddrw <= 5'd0;
		wbforw_valid <= 1'b0;
		pre_accept <= 1'b1;
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);
		pre_accept <= 1'b0;
		drive_random(n_random, 1'b0);
		drive_random(n_mixed, 1'b1);
		// bubble, hold, flush while frozen, plain flush
		apply_cycle(pack_insn(6'h27, 5'd4, 5'd1, 5'd2, 11'h7F3), 0, 0, 0, 0, 5'd0, 0);
		apply_cycle(pack_insn(6'h35, 5'd17, 5'd1, 5'd2, 11'h404), 1, 0, 0, 0, 5'd0, 0);
		apply_cycle(pack_insn(6'h2D, 5'd8, 5'd3, 5'd2, 11'h011), 0, 1, 0, 0, 5'd0, 0);
		apply_cycle(pack_insn(6'h06, 5'd2, 5'd3, 5'd2, 11'h123), 0, 1, 1, 0, 5'd0, 0);
		apply_cycle(pack_insn(6'h38, 5'd3, 5'd3, 5'd2, 11'h006), 0, 0, 1, 0, 5'd0, 0);
		apply_cycle(pack_insn(6'h27, 5'd5, 5'd0, 5'd0, 11'h010), 0, 0, 0, 0, 5'd0, 0);
		// forwarding priority
		apply_cycle(pack_insn(6'h27, 5'd5, 5'd5, 5'd5, 11'h001), 0, 0, 0, 0, 5'd5, 1);
		apply_cycle(pack_insn(6'h27, 5'd6, 5'd5, 5'd5, 11'h002), 0, 0, 0, 1, 5'd5, 1);
		apply_cycle(pack_insn(6'h05, 5'd0, 5'd6, 5'd3, 11'h000), 0, 0, 0, 0, 5'd5, 1);
		apply_cycle(pack_insn(6'h05, 5'd0, 5'd5, 5'd3, 11'h000), 0, 0, 0, 0, 5'd5, 1);
		apply_cycle(pack_insn(6'h05, 5'd0, 5'd5, 5'd3, 11'h000), 0, 0, 0, 0, 5'd5, 0);
		@(posedge clk);
		@(negedge clk);
		// let the last falling-edge checks settle before ending
		@(posedge clk);
		$display("all tests passed");
		$finish;
	end

	initial begin
		#(watchdog_cycles * 100);
		$display("watchdog expired after %0d cycles", watchdog_cycles);
		$display("tests failed");
		$fatal(1, "simulation timeout");
	end

endmodule

/* verilog.f */
+incdir+design
design/id_pkg.sv
design/insn_decoder.sv
design/operand_forward.sv
design/id_ex_stage.sv
design/id_decode_top.sv
tests/id_decode_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ID decode testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module id_decode_tb -f verilog.f -o id_decode_sim; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/id_decode_sim 2>&1)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "all tests passed"; then
	exit 0
fi
exit 1
